/* rv_vectors.txt */
// first word is the vector count, then one vector per line with columns:
// inst  pc  flags (000G_SWRR: G test, S store, W rd write, RR rd)  wdata or store data  store addr
0000002f
00500093 00000000 00010101 00000005 00000000
ffd00113 00000004 00010102 fffffffd 00000000
002081b3 00000008 00010103 00000002 00000000
40208233 0000000c 00010104 00000008 00000000
00409293 00000010 00010105 00000050 00000000
40115313 00000014 00010106 fffffffe 00000000
01c15393 00000018 00010107 0000000f 00000000
00112433 0000001c 00010108 00000001 00000000
001134b3 00000020 00010109 00000000 00000000
0ff0c513 00000024 0001010a 000000fa 00000000
0040e5b3 00000028 0001010b 0000000d 00000000
00417633 0000002c 0001010c 00000008 00000000
123456b7 00000030 0001010d 12345000 00000000
00001717 00000034 0001010e 00001034 00000000
00708013 00000038 00010000 00000000 00000000
001007b3 0000003c 0001010f 00000005 00000000
00f08463 00000040 00020000 00000000 00000000
00f09463 00000048 00020000 00000000 00000000
00114463 0000004c 00020000 00000000 00000000
00117463 00000054 00020000 00000000 00000000
0080086f 0000005c 00020110 00000060 00000000
07900913 00000064 00020112 00000079 00000000
000908e7 00000068 00020111 0000006c 00000000
000019b7 00000078 00030113 00001000 00000000
0029a023 0000007c 00031000 fffffffd 00001000
18500a13 00000080 00030114 00000185 00000000
014982a3 00000084 00031000 00000185 00001005
01499523 00000088 00031000 00000185 0000100a
00598a83 0000008c 00030115 ffffff85 00000000
0059cb03 00000090 00030116 00000085 00000000
00a99b83 00000094 00030117 00000185 00000000
00099c03 00000098 00030118 fffffffd 00000000
0029dc83 0000009c 00030119 0000ffff 00000000
0009ad03 000000a0 0003011a fffffffd 00000000
10000e13 000000a4 0004011c 00000100 00000000
305e1ef3 000000a8 0004011d 00000000 00000000
3000af73 000000ac 0004011e 00001800 00000000
3000bff3 000000b0 0004011f 00001805 00000000
30002ef3 000000b4 0004011d 00001800 00000000
305021f3 000000b8 00040103 00000100 00000000
00000073 000000bc 00050000 00000000 00000000
341022f3 00000100 00050105 000000bc 00000000
34202373 00000104 00050106 0000000b 00000000
00428393 00000108 00050107 000000c0 00000000
34139073 0000010c 00050000 00000000 00000000
30200073 00000110 00050000 00000000 00000000
02a00413 000000c0 00050108 0000002a 00000000

/* rv_core.f */
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_exec.sv
rv_regfile.sv
rv_csr.sv
rv_dmem.sv
rv_core.sv
rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0

/* rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int REC_W   = 5;    // words per vector record
    localparam int RST_CYC = 16;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    commit_t     commit;

    logic [31:0] vmem [0:REC_W*MAX_VEC];  // word 0 holds the vector count
    int          n_vec;
    int          cyc_limit;
    int          cycles;
    int          checks;
    int          errors;
    int          grp_checks;
    int          grp_errors;
    int          cur_grp;

    rv_core DUT (
        .clk    (clk),
        .rst    (rst),
        .inst   (inst),
        .pc     (pc),
        .commit (commit)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic string group_name(input int g);
        case (g)
            0:       return "reset";
            1:       return "alu and immediates";
            2:       return "branches and jumps";
            3:       return "loads and stores";
            4:       return "csr access";
            5:       return "ecall and mret";
            default: return "unnamed";
        endcase
    endfunction

    // test number sits in flags[19:16]
    function automatic int vec_group(input int idx);
        return int'(vmem[1 + REC_W*idx + 2][19:16]);
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        grp_checks++;
        assert (got === exp)
        else
        begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
            grp_errors++;
        end
    endtask

    task automatic check_pc(input int idx, input logic [31:0] exp);
        checks++;
        grp_checks++;
        assert (pc === exp && commit.pc === exp)
        else
        begin
            $display("error pc got %h expected %h, vector %0d is off the expected program path",
                     pc, exp, idx);
            errors++;
            grp_errors++;
        end
    endtask

    task automatic report_group(input int g);
        $display("test %0d (%s) done: %0d checks, %0d errors",
                 g, group_name(g), grp_checks, grp_errors);
        grp_checks = 0;
        grp_errors = 0;
    endtask

    // called on a falling edge, returns on the next one
    task automatic run_vector(input int idx);
        int          base;
        logic [31:0] v_inst;
        logic [31:0] v_pc;
        logic [31:0] v_flags;
        logic [31:0] v_wdata;
        logic [31:0] v_addr;
        base    = 1 + REC_W*idx;
        v_inst  = vmem[base];
        v_pc    = vmem[base + 1];
        v_flags = vmem[base + 2];
        v_wdata = vmem[base + 3];
        v_addr  = vmem[base + 4];
        inst = v_inst;
        #1;  // commit settled, well before the rising edge
        check_pc(idx, v_pc);
        check_field("commit.valid", 32'(commit.valid), 32'd1);
        check_field("commit.rd_we", 32'(commit.rd_we), 32'(v_flags[8]));
        check_field("commit.st_en", 32'(commit.st_en), 32'(v_flags[12]));
        if (v_flags[8])
        begin
            check_field("commit.rd", 32'(commit.rd), 32'(v_flags[7:0]));
            check_field("commit.wdata", commit.wdata, v_wdata);
        end
        if (v_flags[12])
        begin
            check_field("commit.st_addr", commit.st_addr, v_addr);
            check_field("commit.wdata (store data)", commit.wdata, v_wdata);
        end
        @(negedge clk);
    endtask

    initial
    begin
        rst        = 1'b1;
        inst       = 32'h0000_0013;  // nop while in reset
        checks     = 0;
        errors     = 0;
        grp_checks = 0;
        grp_errors = 0;
        $readmemh("rv_vectors.txt", vmem);
        n_vec     = int'(vmem[0]);
        cyc_limit = RST_CYC + n_vec + 32;
        if (n_vec < 1 || n_vec > MAX_VEC)
        begin
            $display("vector file holds an unusable vector count of %0d", n_vec);
            errors++;
        end
        else
        begin
            repeat (RST_CYC - 1) @(posedge clk);
            @(negedge clk);
            #1;
            check_field("commit.valid", 32'(commit.valid), 32'd0);
            check_field("pc", pc, `RV_RESET_PC);
            report_group(0);
            @(negedge clk);           // 16th rising edge has passed
            rst     = 1'b0;
            cur_grp = vec_group(0);
            for (int i = 0; i < n_vec; i++)
            begin
                if (vec_group(i) != cur_grp)
                begin
                    report_group(cur_grp);
                    cur_grp = vec_group(i);
                end
                run_vector(i);
            end
            report_group(cur_grp);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, limit covers reset plus one cycle per vector
    initial
    begin
        cycles = 0;
        @(posedge clk);
        while (cycles < cyc_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cyc_limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_core (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     inst,
    output logic [31:0]     pc,
    output rv_pkg::commit_t commit
);
    import rv_pkg::*;

    ctrl_t       ctrl;
    ctrl_t       ctrl_act;   // ctrl with state writes masked in reset
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_out;
    logic        br_taken;
    logic [31:0] mem_rdata;
    logic [31:0] csr_rdata;
    logic [31:0] trap_pc;
    logic [31:0] wb_data;

    rv_decode u_decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    always_comb
    begin
        ctrl_act = ctrl;
        if (rst)
        begin
            ctrl_act.rd_we  = 1'b0;  // no regfile write while in reset
            ctrl_act.mem_wr = 1'b0;  // no store either
        end
    end

    rv_regfile u_regfile (
        .clk      (clk),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rd       (ctrl.rd),
        .we       (ctrl_act.rd_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_exec u_exec (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_out  (alu_out),
        .br_taken (br_taken)
    );

    rv_dmem u_dmem (
        .clk   (clk),
        .ctrl  (ctrl_act),
        .addr  (alu_out),   // rs1 + offset
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    rv_csr u_csr (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .pc      (pc),
        .wsrc    (rs1_data),
        .rdata   (csr_rdata),
        .trap_pc (trap_pc)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb
    begin
        case (ctrl.wb_sel)
            WB_PC4:  wb_data = pc_plus4;   // jal / jalr link
            WB_ALU:  wb_data = alu_out;
            WB_LOAD: wb_data = mem_rdata;
            WB_CSR:  wb_data = csr_rdata;  // old csr value
            default: wb_data = 32'd0;
        endcase
    end

    always_comb
    begin
        if (ctrl.is_ecall || ctrl.is_mret)
            next_pc = trap_pc;
        else if (ctrl.is_jump || br_taken)
            next_pc = {alu_out[31:1], 1'b0};  // jalr needs bit 0 cleared
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `RV_RESET_PC;
        else
            pc <= next_pc;
    end

    // retire record of the instruction at pc this cycle
    assign commit.valid   = !rst;
    assign commit.pc      = pc;
    assign commit.rd      = ctrl.rd;
    assign commit.rd_we   = ctrl_act.rd_we && (ctrl.rd != 5'd0);
    assign commit.wdata   = ctrl.mem_wr ? rs2_data : wb_data;  // store data on stores
    assign commit.st_en   = ctrl_act.mem_wr;
    assign commit.st_addr = alu_out;

endmodule

`default_nettype wire

/* rv_dmem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_dmem (
    input  logic          clk,
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   addr,
    input  logic [31:0]   wdata,
    output logic [31:0]   rdata
);
    import rv_pkg::*;

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    logic [31:0]   mem [`RV_DMEM_WORDS];
    logic [31:0]   offs;       // byte offset from base
    logic          in_range;
    logic [AW-1:0] idx;
    logic [1:0]    lane;
    logic [3:0]    be;         // byte-lane write enables
    logic [31:0]   wlane;      // store data replicated to lanes
    logic [31:0]   shifted;
    logic [31:0]   ext;

    assign offs     = addr - `RV_DMEM_BASE;
    assign in_range = (offs < 32'(`RV_DMEM_WORDS * 4));  // wraps below base too
    assign idx      = offs[AW+1:2];
    assign lane     = addr[1:0];

    always_comb
    begin
        case (ctrl.mem_size)
            MEM_B, MEM_BU:
            begin
                be    = 4'b0001 << lane;
                wlane = {4{wdata[7:0]}};
            end
            MEM_H, MEM_HU:
            begin
                be    = 4'b0011 << {lane[1], 1'b0};  // low addr bit ignored
                wlane = {2{wdata[15:0]}};
            end
            default:
            begin
                be    = 4'b1111;
                wlane = wdata;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.mem_wr && in_range)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (be[i])
                begin
                    mem[idx][8*i +: 8] <= wlane[8*i +: 8];
                end
            end
        end
    end

    // bring the addressed lane down to bit 0
    assign shifted = mem[idx] >> {lane, 3'b000};

    always_comb
    begin
        case (ctrl.mem_size)
            MEM_B:   ext = {{24{shifted[7]}}, shifted[7:0]};
            MEM_BU:  ext = {24'd0, shifted[7:0]};
            MEM_H:   ext = {{16{shifted[15]}}, shifted[15:0]};
            MEM_HU:  ext = {16'd0, shifted[15:0]};
            default: ext = shifted;
        endcase
    end

    assign rdata = (ctrl.mem_rd && in_range) ? ext : 32'd0;  // out of range reads zero

endmodule

`default_nettype wire

/* rv_csr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_csr (
    input  logic          clk,
    input  logic          rst,
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   wsrc,
    output logic [31:0]   rdata,
    output logic [31:0]   trap_pc
);
    import rv_pkg::*;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    logic [31:0] mstatus, mtvec, mepc, mcause;
    logic [31:0] wval;  // value after rw / rs / rc

    always_comb
    begin
        case (ctrl.csr_addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MTVEC:   rdata = mtvec;
            CSR_MEPC:    rdata = mepc;
            CSR_MCAUSE:  rdata = mcause;
            default:     rdata = 32'd0;  // unimplemented reads as zero
        endcase
    end

    always_comb
    begin
        case (ctrl.csr_op)
            CSR_WRITE: wval = wsrc;
            CSR_SET:   wval = rdata | wsrc;
            CSR_CLEAR: wval = rdata & ~wsrc;
            default:   wval = rdata;
        endcase
    end

    assign trap_pc = ctrl.is_mret ? mepc : mtvec;  // ecall goes to mtvec

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mstatus <= `RV_MSTATUS_RESET;
            mtvec   <= 32'd0;
            mepc    <= 32'd0;
            mcause  <= 32'd0;
        end
        else if (ctrl.is_ecall)
        begin
            mepc   <= pc;                 // pc of the ecall itself
            mcause <= `RV_CAUSE_ECALL_M;
        end
        else if (ctrl.csr_op != CSR_NONE)
        begin
            case (ctrl.csr_addr)
                CSR_MSTATUS: mstatus <= wval;
                CSR_MTVEC:   mtvec   <= wval;
                CSR_MEPC:    mepc    <= wval;
                CSR_MCAUSE:  mcause  <= wval;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];  // entry 0 never written

    always_ff @(posedge clk)
    begin
        if (we && rd != 5'd0)  // drop writes to x0
        begin
            regs[rd] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* rv_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec (
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   rs1_data,
    input  logic [31:0]   rs2_data,
    output logic [31:0]   alu_out,
    output logic          br_taken
);
    import rv_pkg::*;

    logic [31:0] op_a, op_b;
    logic        rs_eq, rs_lt, rs_ltu;

    assign op_a = ctrl.alu_a_pc  ? pc       : rs1_data;
    assign op_b = ctrl.alu_b_imm ? ctrl.imm : rs2_data;

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;  // lui
            default:    alu_out = 32'd0;
        endcase
    end

    // compare always on the register pair, alu busy with the target
    assign rs_eq  = (rs1_data == rs2_data);
    assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign rs_ltu = (rs1_data < rs2_data);

    always_comb
    begin
        case (ctrl.br_op)
            BR_EQ:   br_taken = rs_eq;
            BR_NE:   br_taken = !rs_eq;
            BR_LT:   br_taken = rs_lt;
            BR_GE:   br_taken = !rs_lt;
            BR_LTU:  br_taken = rs_ltu;
            BR_GEU:  br_taken = !rs_ltu;
            default: br_taken = 1'b0;  // not a branch
        endcase
    end

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
    input  logic [31:0]   inst,
    output rv_pkg::ctrl_t ctrl
);
    import rv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        ctrl          = '0;           // all enables low by default
        ctrl.rs1      = inst[19:15];
        ctrl.rs2      = inst[24:20];
        ctrl.rd       = inst[11:7];
        ctrl.csr_addr = inst[31:20];
        case (opcode)
            OP_LUI:
            begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.imm       = imm_u;
                ctrl.wb_sel    = WB_ALU;
                ctrl.rd_we     = 1'b1;
            end
            OP_AUIPC:
            begin
                ctrl.alu_a_pc  = 1'b1;  // pc + imm_u
                ctrl.alu_b_imm = 1'b1;
                ctrl.imm       = imm_u;
                ctrl.wb_sel    = WB_ALU;
                ctrl.rd_we     = 1'b1;
            end
            OP_JAL:
            begin
                ctrl.alu_a_pc  = 1'b1;  // target = pc + imm_j
                ctrl.alu_b_imm = 1'b1;
                ctrl.imm       = imm_j;
                ctrl.is_jump   = 1'b1;
                ctrl.wb_sel    = WB_PC4;  // link
                ctrl.rd_we     = 1'b1;
            end
            OP_JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    ctrl.alu_b_imm = 1'b1;  // target = rs1 + imm_i
                    ctrl.imm       = imm_i;
                    ctrl.is_jump   = 1'b1;
                    ctrl.wb_sel    = WB_PC4;
                    ctrl.rd_we     = 1'b1;
                end
            end
            OP_BRANCH:
            begin
                ctrl.alu_a_pc  = 1'b1;  // alu computes the target
                ctrl.alu_b_imm = 1'b1;
                ctrl.imm       = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_op = BR_EQ;
                    3'b001:  ctrl.br_op = BR_NE;
                    3'b100:  ctrl.br_op = BR_LT;
                    3'b101:  ctrl.br_op = BR_GE;
                    3'b110:  ctrl.br_op = BR_LTU;
                    3'b111:  ctrl.br_op = BR_GEU;
                    default: ctrl.br_op = BR_NONE;  // 010/011 reserved
                endcase
            end
            OP_LOAD:
            begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                begin
                    ctrl.alu_b_imm = 1'b1;
                    ctrl.imm       = imm_i;
                    ctrl.mem_rd    = 1'b1;
                    ctrl.mem_size  = mem_size_e'(funct3);
                    ctrl.wb_sel    = WB_LOAD;
                    ctrl.rd_we     = 1'b1;
                end
            end
            OP_STORE:
            begin
                if (funct3 inside {3'b000, 3'b001, 3'b010})  // sb sh sw
                begin
                    ctrl.alu_b_imm = 1'b1;
                    ctrl.imm       = imm_s;
                    ctrl.mem_wr    = 1'b1;
                    ctrl.mem_size  = mem_size_e'(funct3);
                end
            end
            OP_IMM:
            begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.imm       = imm_i;
                ctrl.alu_op    = alu_from_f3(funct3, (funct3 == 3'b101) && inst[30]);
                ctrl.wb_sel    = WB_ALU;
                ctrl.rd_we     = 1'b1;
            end
            OP_REG:
            begin
                // only 0000000, or 0100000 for sub / sra
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                begin
                    ctrl.alu_op = alu_from_f3(funct3, inst[30]);
                    ctrl.wb_sel = WB_ALU;
                    ctrl.rd_we  = 1'b1;
                end
            end
            OP_SYSTEM:
            begin
                case (funct3)
                    3'b000:
                    begin
                        ctrl.is_ecall = (inst == 32'h0000_0073);
                        ctrl.is_mret  = (inst == 32'h3020_0073);
                    end
                    3'b001, 3'b010, 3'b011:
                    begin
                        ctrl.csr_op = csr_op_e'(funct3[1:0]);  // rw / rs / rc
                        ctrl.wb_sel = WB_CSR;                  // old value to rd
                        ctrl.rd_we  = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;  // unknown opcode, retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // values follow the load funct3 encoding
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    typedef enum logic [2:0] {
        WB_NONE, WB_PC4, WB_ALU, WB_LOAD, WB_CSR
    } wb_sel_e;

    typedef enum logic [1:0] {
        CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR
    } csr_op_e;

    typedef struct packed {
        logic      alu_a_pc;   // operand a from pc, else rs1
        logic      alu_b_imm;  // operand b from imm, else rs2
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      is_jump;    // jal / jalr
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        wb_sel_e   wb_sel;
        logic      rd_we;
        csr_op_e   csr_op;
        logic      is_ecall;
        logic      is_mret;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] csr_addr;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;    // real write, x0 excluded
        logic [31:0] wdata;    // rd value, or store data on a store
        logic        st_en;
        logic [31:0] st_addr;
    } commit_t;

endpackage

`default_nettype wire

/* rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// data memory depth, 32-bit words
`define RV_DMEM_WORDS 256

// data memory decodes from here upward
`define RV_DMEM_BASE 32'h0000_1000

// machine trap cause for ecall from M-mode
`define RV_CAUSE_ECALL_M 32'd11

// mstatus value after reset, MPP = machine
`define RV_MSTATUS_RESET 32'h0000_1800

`endif
